//--- common/mipsParams.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Datapath widths
`define WORD_W 32
`define REG_COUNT 32

// Memories, sized in words
`define IMEM_DEPTH 256
`define IMEM_AW 8
`define DMEM_DEPTH 256
`define DMEM_AW 8

`define RESET_PC 32'h0000_0000

// Limits for loaded program images
`define PROG_MAX_WORDS `IMEM_DEPTH
`define PROG_MAX_TESTS 8

`endif

//--- common/isaPkg.sv
`default_nettype none
`include "mipsParams.svh"

package isaPkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [15:0] imm_t;

	// Primary opcodes in use
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDIU = 6'h09,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_LUI
	} aluOp_e;

	typedef struct packed {
		opcode_e opcode;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [4:0] shamt;
		funct_e funct;
	} rType_t;

	typedef struct packed {
		opcode_e opcode;
		regAddr_t rs;
		regAddr_t rt;
		imm_t imm;
	} iType_t;

	// Same 32 bits seen as either format
	typedef union packed {
		rType_t r;
		iType_t i;
	} instr_t;

endpackage

`default_nettype wire

//--- common/pipePkg.sv
`default_nettype none
`include "mipsParams.svh"

package pipePkg;
	import isaPkg::*;

	typedef logic [`WORD_W-1:0] pc_t;

	typedef struct packed {
		logic valid;
		pc_t pc;
		word_t instr;
	} fetchToDecode_t;

	typedef struct packed {
		logic valid;
		aluOp_e aluOp;
		logic useImm; // B operand is the extended immediate
		regAddr_t rs;
		regAddr_t rt;
		word_t rsValue;
		word_t rtValue;
		word_t imm;
		regAddr_t dest;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic branch;
		pc_t pc;
	} decodeToExec_t;

	typedef struct packed {
		logic valid;
		word_t aluResult; // Also the data address
		word_t storeData;
		regAddr_t dest;
		logic regWrite;
		logic memRead;
		logic memWrite;
	} execToMem_t;

	typedef struct packed {
		logic taken;
		pc_t target;
	} redirect_t;

	// Register file write port and WB forward source
	typedef struct packed {
		logic valid;
		regAddr_t dest;
		word_t data;
	} wbBypass_t;

	typedef struct packed {
		logic valid;
		regAddr_t dest;
		word_t data;
	} retire_t;

	typedef struct packed {
		logic valid;
		word_t addr;
		word_t data;
	} storeBus_t;

	typedef struct packed {
		logic valid;
		logic [`IMEM_AW-1:0] index;
		word_t instr;
	} progLoad_t;

endpackage

`default_nettype wire

//--- fetch/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsParams.svh"

module fetchStage import pipePkg::*; (
	input wire logic Clk,
	input wire logic rstN,
	input wire logic run,
	input wire progLoad_t prog,
	input wire logic stall,
	input wire redirect_t redirect,
	output fetchToDecode_t toDecode
);

	logic [`WORD_W-1:0] imem [`IMEM_DEPTH];
	pc_t pc;
	logic [`IMEM_AW-1:0] fetchIdx;

	assign fetchIdx = pc[`IMEM_AW+1:2]; // Word index

	// Program loader
	always_ff @(posedge Clk) begin
		if (prog.valid)
			imem[prog.index] <= prog.instr;
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			pc <= `RESET_PC;
			toDecode <= '0;
		end else if (redirect.taken) begin
			pc <= redirect.target;
			toDecode.valid <= 1'b0; // Squash the wrong-path fetch
		end else if (!stall) begin
			toDecode.valid <= run;
			toDecode.pc <= pc;
			toDecode.instr <= imem[fetchIdx];
			if (run)
				pc <= pc + 32'd4;
		end
	end

	// Loading is only legal while the core is halted
	progWhileHalted: assert property (@(posedge Clk) disable iff (!rstN)
		prog.valid |-> !run)
		else $error("prog write while run is high");

endmodule

`default_nettype wire

//--- decode/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsParams.svh"

module decodeStage import isaPkg::*, pipePkg::*; (
	input wire logic Clk,
	input wire logic rstN,
	input wire fetchToDecode_t fromFetch,
	input wire redirect_t redirect,
	input wire wbBypass_t writeBack,
	output logic stall,
	output decodeToExec_t toExec
);

	word_t regs [`REG_COUNT];

	instr_t ins;
	aluOp_e aluOp;
	logic useImm;
	logic signExt;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic branch;
	regAddr_t dest;
	word_t extImm;
	word_t rsValue;
	word_t rtValue;
	decodeToExec_t nextEx;

	assign ins = fromFetch.instr;

	// Read with same-cycle write-through and $0 hardwired
	function automatic word_t readReg(regAddr_t r, word_t stored, wbBypass_t wb);
		if (r == '0)
			return '0;
		if (wb.valid && wb.dest == r)
			return wb.data;
		return stored;
	endfunction

	always_ff @(posedge Clk) begin
		if (writeBack.valid)
			regs[writeBack.dest] <= writeBack.data;
	end

	assign rsValue = readReg(ins.r.rs, regs[ins.r.rs], writeBack);
	assign rtValue = readReg(ins.r.rt, regs[ins.r.rt], writeBack);

	always_comb begin
		aluOp = ALU_ADD;
		useImm = 1'b0;
		signExt = 1'b1;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		dest = ins.i.rt; // I-type default
		case (ins.r.opcode)
			OP_RTYPE: begin
				dest = ins.r.rd;
				regWrite = 1'b1;
				case (ins.r.funct)
					FN_ADDU: aluOp = ALU_ADD;
					FN_SUBU: aluOp = ALU_SUB;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_XOR: aluOp = ALU_XOR;
					FN_NOR: aluOp = ALU_NOR;
					FN_SLT: aluOp = ALU_SLT;
					default: regWrite = 1'b0; // Unknown funct is a no-op
				endcase
			end
			OP_ADDIU: begin
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			OP_ANDI: begin
				aluOp = ALU_AND;
				useImm = 1'b1;
				signExt = 1'b0;
				regWrite = 1'b1;
			end
			OP_ORI: begin
				aluOp = ALU_OR;
				useImm = 1'b1;
				signExt = 1'b0;
				regWrite = 1'b1;
			end
			OP_LUI: begin
				aluOp = ALU_LUI;
				useImm = 1'b1;
				signExt = 1'b0;
				regWrite = 1'b1;
			end
			OP_LW: begin
				useImm = 1'b1;
				memRead = 1'b1;
				regWrite = 1'b1;
			end
			OP_SW: begin
				useImm = 1'b1;
				memWrite = 1'b1;
			end
			OP_BEQ: branch = 1'b1; // Compared and resolved in EX
			default: ;
		endcase
	end

	assign extImm = signExt ? {{16{ins.i.imm[15]}}, ins.i.imm} : {16'h0000, ins.i.imm};

	always_comb begin
		nextEx.valid = fromFetch.valid;
		nextEx.aluOp = aluOp;
		nextEx.useImm = useImm;
		nextEx.rs = ins.r.rs;
		nextEx.rt = ins.r.rt;
		nextEx.rsValue = rsValue;
		nextEx.rtValue = rtValue;
		nextEx.imm = extImm;
		nextEx.dest = dest;
		nextEx.regWrite = regWrite;
		nextEx.memRead = memRead;
		nextEx.memWrite = memWrite;
		nextEx.branch = branch;
		nextEx.pc = fromFetch.pc;
	end

	// Load-use hazard against the entry now in EX
	assign stall = toExec.valid && toExec.memRead && toExec.dest != '0 && fromFetch.valid &&
		(toExec.dest == ins.r.rs || toExec.dest == ins.r.rt);

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			toExec <= '0;
		else if (redirect.taken || stall)
			toExec <= '0; // Bubble
		else
			toExec <= nextEx;
	end

	noZeroWrite: assert property (@(posedge Clk) disable iff (!rstN)
		writeBack.valid |-> writeBack.dest != '0)
		else $error("write to register 0");

endmodule

`default_nettype wire

//--- execute/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import isaPkg::*, pipePkg::*; (
	input wire logic Clk,
	input wire logic rstN,
	input wire decodeToExec_t fromDecode,
	input wire wbBypass_t writeBack,
	output redirect_t redirect,
	output execToMem_t toMem
);

	word_t rsFwd;
	word_t rtFwd;
	word_t opB;
	word_t aluOut;
	execToMem_t nextMem;

	// MEM result first, then WB, then the value read in ID
	function automatic word_t forward(regAddr_t r, word_t regVal, execToMem_t mem,
		wbBypass_t wb);
		if (r != '0 && mem.valid && mem.regWrite && !mem.memRead && mem.dest == r)
			return mem.aluResult;
		if (wb.valid && wb.dest == r)
			return wb.data;
		return regVal;
	endfunction

	assign rsFwd = forward(fromDecode.rs, fromDecode.rsValue, toMem, writeBack);
	assign rtFwd = forward(fromDecode.rt, fromDecode.rtValue, toMem, writeBack);
	assign opB = fromDecode.useImm ? fromDecode.imm : rtFwd;

	always_comb begin
		case (fromDecode.aluOp)
			ALU_ADD: aluOut = rsFwd + opB;
			ALU_SUB: aluOut = rsFwd - opB;
			ALU_AND: aluOut = rsFwd & opB;
			ALU_OR: aluOut = rsFwd | opB;
			ALU_XOR: aluOut = rsFwd ^ opB;
			ALU_NOR: aluOut = ~(rsFwd | opB);
			ALU_SLT: aluOut = word_t'($signed(rsFwd) < $signed(opB));
			ALU_LUI: aluOut = {opB[15:0], 16'h0000};
			default: aluOut = '0;
		endcase
	end

	// BEQ predicted not taken
	assign redirect.taken = fromDecode.valid && fromDecode.branch && (rsFwd == rtFwd);
	assign redirect.target = fromDecode.pc + 32'd4 + {fromDecode.imm[29:0], 2'b00};

	always_comb begin
		nextMem.valid = fromDecode.valid;
		nextMem.aluResult = aluOut;
		nextMem.storeData = rtFwd;
		nextMem.dest = fromDecode.dest;
		nextMem.regWrite = fromDecode.regWrite;
		nextMem.memRead = fromDecode.memRead;
		nextMem.memWrite = fromDecode.memWrite;
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			toMem <= '0;
		else
			toMem <= nextMem;
	end

	// Decode must have stalled any consumer of a load still in MEM
	loadUseCovered: assert property (@(posedge Clk) disable iff (!rstN)
		(toMem.valid && toMem.memRead && toMem.dest != '0 && fromDecode.valid) |->
		(toMem.dest != fromDecode.rs && toMem.dest != fromDecode.rt))
		else $error("load result needed from MEM");

endmodule

`default_nettype wire

//--- design/memWriteback.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsParams.svh"

module memWriteback import pipePkg::*; (
	input wire logic Clk,
	input wire logic rstN,
	input wire execToMem_t fromExec,
	output storeBus_t store,
	output wbBypass_t writeBack,
	output retire_t retire
);

	logic [`WORD_W-1:0] dmem [`DMEM_DEPTH];
	logic [`DMEM_AW-1:0] wordIdx;
	logic [`WORD_W-1:0] loadData;
	wbBypass_t memWb;

	assign wordIdx = fromExec.aluResult[`DMEM_AW+1:2];
	assign loadData = dmem[wordIdx]; // Asynchronous read

	always_ff @(posedge Clk) begin
		if (store.valid)
			dmem[wordIdx] <= fromExec.storeData;
	end

	assign store.valid = fromExec.valid && fromExec.memWrite;
	assign store.addr = fromExec.aluResult;
	assign store.data = fromExec.storeData;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			memWb <= '0;
		end else begin
			memWb.valid <= fromExec.valid && fromExec.regWrite && fromExec.dest != '0;
			memWb.dest <= fromExec.dest;
			memWb.data <= fromExec.memRead ? loadData : fromExec.aluResult;
		end
	end

	assign writeBack = memWb;

	// Retire mirrors the register file write
	assign retire.valid = memWb.valid;
	assign retire.dest = memWb.dest;
	assign retire.data = memWb.data;

	storeAligned: assert property (@(posedge Clk) disable iff (!rstN)
		store.valid |-> store.addr[1:0] == 2'b00)
		else $error("unaligned store address %h", store.addr);

endmodule

`default_nettype wire

//--- design/mipsPipe.sv
`timescale 1ns/1ps
`default_nettype none

module mipsPipe import pipePkg::*; (
	input wire logic Clk,
	input wire logic rstN,
	input wire logic run,
	input wire progLoad_t prog,
	output retire_t retire,
	output storeBus_t store
);

	fetchToDecode_t ifId;
	decodeToExec_t idEx;
	execToMem_t exMem;
	redirect_t redirect;
	wbBypass_t writeBack;
	logic stall;

	fetchStage i_fetchStage (
		.Clk(Clk),
		.rstN(rstN),
		.run(run),
		.prog(prog),
		.stall(stall),
		.redirect(redirect),
		.toDecode(ifId)
	);

	decodeStage i_decodeStage (
		.Clk(Clk),
		.rstN(rstN),
		.fromFetch(ifId),
		.redirect(redirect),
		.writeBack(writeBack),
		.stall(stall),
		.toExec(idEx)
	);

	executeStage i_executeStage (
		.Clk(Clk),
		.rstN(rstN),
		.fromDecode(idEx),
		.writeBack(writeBack),
		.redirect(redirect),
		.toMem(exMem)
	);

	memWriteback i_memWriteback (
		.Clk(Clk),
		.rstN(rstN),
		.fromExec(exMem),
		.store(store),
		.writeBack(writeBack),
		.retire(retire)
	);

endmodule

`default_nettype wire

//--- testbench/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

function automatic word_t encR(funct_e fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
	return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t encI(opcode_e op, regAddr_t rt, regAddr_t rs, imm_t imm);
	return {op, rs, rt, imm};
endfunction

// BEQ $0,$0,-1 spins on itself
localparam word_t HALT = {OP_BEQ, 5'd0, 5'd0, 16'hffff};

// Architectural run of one program that fills the expected queues
task automatic modelRun(input int t, output int executed);
	word_t r [`REG_COUNT];
	word_t m [`DMEM_DEPTH];
	word_t pc;
	word_t ins;
	word_t a;
	word_t b;
	word_t addr;
	word_t sImm;
	word_t res;
	regAddr_t dest;
	logic wr;
	r = '{default: '0};
	m = '{default: '0};
	pc = `RESET_PC;
	executed = 0;
	ins = progMem[t][pc[`IMEM_AW+1:2]];
	while (ins != HALT && executed < `PROG_MAX_WORDS * 4) begin
		a = r[ins[25:21]];
		b = r[ins[20:16]];
		sImm = {{16{ins[15]}}, ins[15:0]};
		addr = a + sImm;
		dest = ins[20:16];
		wr = 1'b1;
		res = '0;
		pc = pc + 32'd4;
		case (ins[31:26])
			OP_RTYPE: begin
				dest = ins[15:11];
				case (ins[5:0])
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND: res = a & b;
					FN_OR: res = a | b;
					FN_XOR: res = a ^ b;
					FN_NOR: res = ~(a | b);
					FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			OP_ADDIU: res = a + sImm;
			OP_ANDI: res = a & {16'h0000, ins[15:0]}; // Zero extended
			OP_ORI: res = a | {16'h0000, ins[15:0]};
			OP_LUI: res = {ins[15:0], 16'h0000};
			OP_LW: res = m[addr[`DMEM_AW+1:2]];
			OP_SW: begin
				wr = 1'b0;
				m[addr[`DMEM_AW+1:2]] = b;
				storeQ.push_back({1'b1, addr, b});
			end
			OP_BEQ: begin
				wr = 1'b0;
				if (a == b)
					pc = pc + (sImm << 2);
			end
			default: wr = 1'b0;
		endcase
		if (wr && dest != '0) begin
			r[dest] = res;
			retireQ.push_back({1'b1, dest, res});
		end
		executed++;
		ins = progMem[t][pc[`IMEM_AW+1:2]];
	end
endtask

`endif

//--- testbench/mipsPipeTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsParams.svh"

module mipsPipeTb import isaPkg::*, pipePkg::*; ();

	localparam int NUM_TESTS = 6;

	logic Clk;
	logic rstN;
	logic run;
	progLoad_t prog;
	retire_t retire;
	storeBus_t store;

	word_t progMem [`PROG_MAX_TESTS][`PROG_MAX_WORDS];
	int progLen [`PROG_MAX_TESTS];
	string testName [NUM_TESTS];
	int curTest;
	retire_t retireQ [$];
	storeBus_t storeQ [$];
	retire_t retireHead;
	storeBus_t storeHead;
	int retireLeft = 0;
	int storeLeft = 0;
	int errCount = 0;
	int testsFailed = 0;
	int cycles = 0;
	int cycleLimit = 0;
	funct_e functs [7] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};

	`include "refModel.svh"

	mipsPipe i_mipsPipe (
		.Clk(Clk),
		.rstN(rstN),
		.run(run),
		.prog(prog),
		.retire(retire),
		.store(store)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// Drop expected entries as the DUT produces them
	always @(posedge Clk) begin
		if (retire.valid && retireQ.size() != 0)
			void'(retireQ.pop_front());
		if (store.valid && storeQ.size() != 0)
			void'(storeQ.pop_front());
		retireLeft = retireQ.size();
		storeLeft = storeQ.size();
		if (retireLeft != 0)
			retireHead = retireQ[0];
		if (storeLeft != 0)
			storeHead = storeQ[0];
	end

	retireExpected: assert property (@(negedge Clk) disable iff (!rstN)
		retire.valid |-> retireLeft != 0)
		else begin
			errCount++;
			$display("%0t: r%0d retired but the model has no retire left", $time, retire.dest);
		end

	retireMatches: assert property (@(negedge Clk) disable iff (!rstN)
		(retire.valid && retireLeft != 0) |->
		(retire.dest == retireHead.dest && retire.data == retireHead.data))
		else begin
			errCount++;
			$display("ERROR %0t retire expected r%0d=%h got r%0d=%h", $time,
				retireHead.dest, retireHead.data, retire.dest, retire.data);
		end

	storeExpected: assert property (@(negedge Clk) disable iff (!rstN)
		store.valid |-> storeLeft != 0)
		else begin
			errCount++;
			$display("%0t: store to %h but the model has no store left", $time, store.addr);
		end

	storeMatches: assert property (@(negedge Clk) disable iff (!rstN)
		(store.valid && storeLeft != 0) |->
		(store.addr == storeHead.addr && store.data == storeHead.data))
		else begin
			errCount++;
			$display("ERROR %0t store expected [%h]=%h got [%h]=%h", $time,
				storeHead.addr, storeHead.data, store.addr, store.data);
		end

	// Only running cycles count against the budget
	initial begin
		wait (cycleLimit != 0);
		while (cycles < cycleLimit) begin
			@(posedge Clk);
			if (run)
				cycles++;
		end
		$display("Timeout: %0d running cycles and strobes still missing", cycles);
		$display("Finished with errors");
		$finish;
	end

	task automatic emit(input word_t w);
		progMem[curTest][progLen[curTest]] = w;
		progLen[curTest]++;
	endtask

	function automatic regAddr_t pickReg(input int lo, input int hi);
		return regAddr_t'(lo + $urandom % (hi - lo + 1));
	endfunction

	// ORI reads the LUI result from MEM
	task automatic loadConst(input regAddr_t r, input word_t v);
		emit(encI(OP_LUI, r, 5'd0, v[31:16]));
		emit(encI(OP_ORI, r, r, v[15:0]));
	endtask

	task automatic initRegs(input int last);
		for (int r = 1; r <= last; r++)
			loadConst(regAddr_t'(r), $urandom());
	endtask

	task automatic buildPrograms();
		regAddr_t last;
		regAddr_t prev;
		regAddr_t dst;
		for (int t = 0; t < `PROG_MAX_TESTS; t++)
			progLen[t] = 0;

		curTest = 0;
		testName[0] = "R-type ALU";
		initRegs(15);
		repeat (24)
			emit(encR(functs[$urandom % 7], pickReg(1, 15), pickReg(1, 15), pickReg(1, 15)));
		emit(HALT);

		curTest = 1;
		testName[1] = "immediates";
		initRegs(8);
		emit(encI(OP_ADDIU, 5'd9, 5'd1, 16'h8001)); // Negative immediate
		emit(encI(OP_ANDI, 5'd10, 5'd2, 16'hffff));
		repeat (6) begin
			emit(encI(OP_ADDIU, pickReg(9, 15), pickReg(1, 8), imm_t'($urandom)));
			emit(encI(OP_ANDI, pickReg(9, 15), pickReg(1, 8), imm_t'($urandom)));
			emit(encI(OP_ORI, pickReg(9, 15), pickReg(1, 8), imm_t'($urandom)));
			emit(encI(OP_LUI, pickReg(9, 15), 5'd0, imm_t'($urandom)));
		end
		emit(HALT);

		curTest = 2;
		testName[2] = "forwarding";
		initRegs(4);
		last = 5'd1;
		prev = 5'd2;
		repeat (20) begin
			dst = pickReg(5, 15);
			emit(encR(functs[$urandom % 7], dst, last, prev)); // MEM and WB sources
			prev = last;
			last = dst;
		end
		emit(encI(OP_SW, last, 5'd0, 16'h0010));
		emit(HALT);

		curTest = 3;
		testName[3] = "load and store";
		initRegs(4);
		emit(encI(OP_ADDIU, 5'd20, 5'd0, 16'h0040));
		emit(encI(OP_SW, 5'd1, 5'd20, 16'h0000));
		emit(encI(OP_LW, 5'd21, 5'd20, 16'h0000));
		emit(encR(FN_ADDU, 5'd22, 5'd21, 5'd2)); // Load-use stall
		emit(encI(OP_SW, 5'd22, 5'd20, 16'h0004));
		emit(encI(OP_LW, 5'd23, 5'd20, 16'h0004));
		emit(encI(OP_SW, 5'd23, 5'd20, 16'hfffc)); // Stall on the store data
		emit(encI(OP_LW, 5'd24, 5'd20, 16'hfffc));
		emit(encR(FN_XOR, 5'd25, 5'd3, 5'd24));
		emit(encI(OP_LW, 5'd26, 5'd20, 16'h0000));
		emit(encR(FN_OR, 5'd27, 5'd4, 5'd0));
		emit(encR(FN_SUBU, 5'd28, 5'd26, 5'd4)); // Load value from WB
		emit(HALT);

		curTest = 4;
		testName[4] = "branches";
		initRegs(4);
		emit(encI(OP_ADDIU, 5'd5, 5'd0, 16'd7));
		emit(encI(OP_ADDIU, 5'd6, 5'd0, 16'd7));
		emit(encI(OP_BEQ, 5'd6, 5'd5, 16'd2)); // Taken
		emit(encI(OP_ADDIU, 5'd7, 5'd0, 16'd1));
		emit(encI(OP_SW, 5'd1, 5'd0, 16'h0020));
		emit(encI(OP_ADDIU, 5'd8, 5'd5, 16'd1));
		emit(encI(OP_BEQ, 5'd8, 5'd5, 16'd2)); // Not taken
		emit(encI(OP_ADDIU, 5'd9, 5'd8, 16'd2));
		emit(encI(OP_SW, 5'd9, 5'd0, 16'h0024));
		emit(encR(FN_ADDU, 5'd10, 5'd9, 5'd1));
		repeat (6) begin
			emit(encI(OP_BEQ, ($urandom % 2) ? 5'd6 : 5'd8, 5'd5, 16'd1));
			emit(encI(OP_ADDIU, pickReg(11, 15), pickReg(1, 4), imm_t'($urandom)));
			emit(encR(FN_ADDU, pickReg(11, 15), pickReg(1, 4), pickReg(5, 6)));
		end
		emit(HALT);

		curTest = 5;
		testName[5] = "register 0";
		initRegs(3);
		emit(encR(FN_ADDU, 5'd0, 5'd1, 5'd2));
		emit(encI(OP_ADDIU, 5'd0, 5'd0, 16'h1234));
		emit(encR(FN_OR, 5'd4, 5'd0, 5'd3)); // Reads zero
		emit(encI(OP_LUI, 5'd0, 5'd0, 16'hbeef));
		emit(encI(OP_SW, 5'd0, 5'd0, 16'h0030));
		emit(encI(OP_LW, 5'd0, 5'd0, 16'h0030));
		emit(encR(FN_ADDU, 5'd5, 5'd0, 5'd1));
		emit(HALT);
	endtask

	task automatic runTest(input int t);
		int executed;
		int errBefore;
		errBefore = errCount;
		@(posedge Clk);
		rstN <= 1'b0;
		run <= 1'b0;
		repeat (3) @(posedge Clk);
		rstN <= 1'b1;
		// Two trailing no-ops fill the slots fetched behind the halt
		for (int i = 0; i < progLen[t] + 2; i++) begin
			prog.valid <= 1'b1;
			prog.index <= i[`IMEM_AW-1:0];
			prog.instr <= (i < progLen[t]) ? progMem[t][i] : '0;
			@(posedge Clk);
		end
		prog.valid <= 1'b0;
		modelRun(t, executed);
		@(posedge Clk);
		run <= 1'b1;
		while (retireQ.size() != 0 || storeQ.size() != 0)
			@(posedge Clk);
		repeat (8) @(posedge Clk); // Halt loop must stay silent
		run <= 1'b0;
		if (errCount != errBefore)
			testsFailed++;
		$display("Test %0d %s: %0d instructions, %0s", t, testName[t], executed,
			(errCount == errBefore) ? "passed" : "failed");
	endtask

	initial begin
		int executed;
		int limit;
		rstN = 1'b0;
		run = 1'b0;
		prog = '0;
		void'($urandom(56));
		buildPrograms();
		limit = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			modelRun(t, executed);
			limit += 4 * executed + 50;
		end
		retireQ.delete();
		storeQ.delete();
		cycleLimit = limit;
		for (int t = 0; t < NUM_TESTS; t++)
			runTest(t);
		$display("Tests %0d, failed %0d, errors %0d, running cycles %0d of %0d",
			NUM_TESTS, testsFailed, errCount, cycles, cycleLimit);
		if (errCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- mipsPipe.f
+incdir+common
+incdir+testbench
common/isaPkg.sv
common/pipePkg.sv
fetch/fetchStage.sv
decode/decodeStage.sv
execute/executeStage.sv
design/memWriteback.sv
design/mipsPipe.sv
testbench/mipsPipeTb.sv

//--- Makefile
TOP = mipsPipeTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f mipsPipe.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
